// File: noc_pkg.sv
`default_nettype none

package noc_pkg;

  // ########################################
  // Sizing
  // ########################################

  // Virtual channels, one buffer each
  localparam int VC_COUNT = 4;
  localparam int VC_W = 2;

  // Entries per channel buffer
  localparam int BUF_DEPTH = 4;
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
  // One more state than entries for the occupancy count
  localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

  localparam int DATA_W = 32;

  // ########################################
  // Flit format
  // ########################################

  // Head flit body
  typedef struct packed {
    logic [7:0] dest;
    logic [7:0] src;
    logic [7:0] length;
    logic [7:0] tag;
  } flit_header_t;

  // Same word, read as header on a head flit and as data otherwise
  typedef union packed {
    flit_header_t      header;
    logic [DATA_W-1:0] payload;
  } flit_body_u;

  // Single-flit packet has head and tail both set
  typedef struct packed {
    logic            head;
    logic            tail;
    logic [VC_W-1:0] vc;
    flit_body_u      body;
  } flit_t;

endpackage

`default_nettype wire

// File: flit_vc_demux.sv
`timescale 1ns/1ps
`default_nettype none

module flit_vc_demux (
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  noc_pkg::flit_t                         in_flit,
  output logic [noc_pkg::VC_COUNT-1:0]           buf_valid,
  input  logic [noc_pkg::VC_COUNT-1:0]           buf_ready,
  output noc_pkg::flit_t [noc_pkg::VC_COUNT-1:0] buf_flit
);
  import noc_pkg::*;

  // ########################################
  // Valid steering
  // ########################################

  // One-hot valid from the vc field
  always_comb begin
    buf_valid = '0;
    buf_valid[in_flit.vc] = in_valid;
  end

  // Flit goes to every buffer, only one sees valid
  for (genvar i = 0; i < VC_COUNT; i++) begin : g_flit
    assign buf_flit[i] = in_flit;
  end

  // ########################################
  // Ready return
  // ########################################

  // Full buffer stalls only its own channel
  assign in_ready = buf_ready[in_flit.vc];

endmodule

`default_nettype wire

// File: vc_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vc_buffer (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  output logic           in_ready,
  input  noc_pkg::flit_t in_flit,
  output logic           out_valid,
  input  logic           out_ready,
  output noc_pkg::flit_t out_flit
);
  import noc_pkg::*;

  flit_t                mem [BUF_DEPTH];
  logic [BUF_PTR_W-1:0] wr_ptr;
  logic [BUF_PTR_W-1:0] rd_ptr;
  logic [BUF_CNT_W-1:0] count;
  logic                 push;
  logic                 pop;
  logic                 full;

  // ########################################
  // Handshakes
  // ########################################

  assign full = (count == BUF_CNT_W'(BUF_DEPTH));
  assign out_valid = (count != '0);
  assign pop = out_valid && out_ready;

  // When full, a read in the same cycle frees the slot
  assign in_ready = !full || pop;
  assign push = in_valid && in_ready;

  // Head entry, no bypass from the write side
  assign out_flit = mem[rd_ptr];

  // ########################################
  // Storage and pointers
  // ########################################

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + BUF_PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + BUF_PTR_W'(1);
      end
      // Simultaneous push and pop leave the count alone
      case ({push, pop})
        2'b10:   count <= count + BUF_CNT_W'(1);
        2'b01:   count <= count - BUF_CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: vc_packet_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module vc_packet_arbiter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [noc_pkg::VC_COUNT-1:0]           req_valid,
  output logic [noc_pkg::VC_COUNT-1:0]           req_ready,
  input  noc_pkg::flit_t [noc_pkg::VC_COUNT-1:0] req_flit,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output noc_pkg::flit_t                         out_flit,
  output logic [7:0]                             out_dest
);
  import noc_pkg::*;

  // Round-robin state and packet lock
  logic [VC_W-1:0] rr_ptr;
  logic            locked;
  logic [VC_W-1:0] lock_idx;
  logic [7:0]      dest_q;

  logic [VC_W-1:0] scan_idx;
  logic            pick_found;
  logic [VC_W-1:0] pick_idx;
  logic [VC_W-1:0] grant_idx;
  logic            accept;

  // ########################################
  // Head search from the pointer
  // ########################################

  // Index arithmetic wraps at VC_COUNT since VC_COUNT is 2**VC_W
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = rr_ptr;
    scan_idx   = rr_ptr;
    for (int k = 0; k < VC_COUNT; k++) begin
      scan_idx = rr_ptr + VC_W'(k);
      if (!pick_found && req_valid[scan_idx] && req_flit[scan_idx].head) begin
        pick_found = 1'b1;
        pick_idx   = scan_idx;
      end
    end
  end

  // ########################################
  // Output mux
  // ########################################

  // Locked packet keeps the output even if its buffer runs dry
  assign grant_idx = locked ? lock_idx : pick_idx;
  assign out_valid = locked ? req_valid[lock_idx] : pick_found;
  assign out_flit  = req_flit[grant_idx];
  assign accept    = out_valid && out_ready;

  // Ready goes back to the granted buffer only
  always_comb begin
    req_ready = '0;
    req_ready[grant_idx] = out_ready && out_valid;
  end

  // Header decode while the head is offered, held copy after that
  assign out_dest = locked ? dest_q : out_flit.body.header.dest;

  // ########################################
  // Lock and pointer update
  // ########################################

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr   <= '0;
      locked   <= 1'b0;
      lock_idx <= '0;
    end else if (accept) begin
      if (out_flit.tail) begin
        // End of packet, also covers single-flit packets
        locked <= 1'b0;
        rr_ptr <= grant_idx + VC_W'(1);
      end else if (out_flit.head) begin
        locked   <= 1'b1;
        lock_idx <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && out_flit.head) begin
      dest_q <= out_flit.body.header.dest;
    end
  end

endmodule

`default_nettype wire

// File: noc_vc_mux_top.sv
`timescale 1ns/1ps
`default_nettype none

module noc_vc_mux_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  output logic           in_ready,
  input  noc_pkg::flit_t in_flit,
  output logic           out_valid,
  input  logic           out_ready,
  output noc_pkg::flit_t out_flit,
  output logic [7:0]     out_dest
);
  import noc_pkg::*;

  logic [VC_COUNT-1:0]  buf_in_valid;
  logic [VC_COUNT-1:0]  buf_in_ready;
  flit_t [VC_COUNT-1:0] buf_in_flit;
  logic [VC_COUNT-1:0]  buf_out_valid;
  logic [VC_COUNT-1:0]  buf_out_ready;
  flit_t [VC_COUNT-1:0] buf_out_flit;

  // ########################################
  // Input steering
  // ########################################

  flit_vc_demux u_demux (
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .buf_valid (buf_in_valid),
    .buf_ready (buf_in_ready),
    .buf_flit  (buf_in_flit)
  );

  // ########################################
  // Channel buffers
  // ########################################

  for (genvar i = 0; i < VC_COUNT; i++) begin : g_vc
    vc_buffer u_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (buf_in_valid[i]),
      .in_ready  (buf_in_ready[i]),
      .in_flit   (buf_in_flit[i]),
      .out_valid (buf_out_valid[i]),
      .out_ready (buf_out_ready[i]),
      .out_flit  (buf_out_flit[i])
    );
  end

  // Packet arbitration onto the single output
  vc_packet_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .req_valid (buf_out_valid),
    .req_ready (buf_out_ready),
    .req_flit  (buf_out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit),
    .out_dest  (out_dest)
  );

endmodule

`default_nettype wire

// File: tb_noc_vc_mux.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noc_vc_mux;
  import noc_pkg::*;

  localparam int PAT_MAX     = 64;
  localparam int FAIR_N      = 8;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 4000;
  localparam int READY_LOW   = 0;
  localparam int READY_HIGH  = 1;
  localparam int READY_RAND  = 2;

  logic       clk;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  flit_t      in_flit;
  logic       out_valid;
  logic       out_ready;
  flit_t      out_flit;
  logic [7:0] out_dest;

  // Pattern records and per-channel expected flits
  logic [39:0]     pat_mem [PAT_MAX];
  flit_t           ref_q [VC_COUNT][$];
  int              pat_count;
  int              send_idx;
  int              send_end;
  int              seed;
  int              ready_mode;
  logic            random_gaps;
  logic            fair_order;
  logic            in_done;
  logic            last_out_fire;
  int              occ [VC_COUNT];
  int              out_count;
  int              full_hits;
  logic            in_pkt;
  logic [VC_W-1:0] pkt_vc;
  logic [7:0]      pkt_dest;

  noc_vc_mux_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit),
    .out_dest  (out_dest)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ########################################
  // Reporting
  // ########################################

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual,
               expected);
      $display("CHECKS FAILED");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1, "Stopping on timeout");
  endtask

  // ########################################
  // Reference model
  // ########################################

  // Records of kind 1 are flits and anything else ends the list
  task automatic load_references;
    flit_t f;
    pat_count = 0;
    while (pat_count < PAT_MAX && pat_mem[pat_count][39:36] == 4'h1) begin
      f = pat_mem[pat_count][35:0];
      ref_q[f.vc].push_back(f);
      pat_count++;
    end
  endtask

  // Full buffer blocks its channel unless it is popped this cycle
  task automatic check_in_ready;
    int   v;
    logic pop_same;
    v = int'(in_flit.vc);
    pop_same = out_valid && out_ready && (out_flit.vc == in_flit.vc);
    if (occ[v] < BUF_DEPTH) begin
      check_value(64'(in_ready), 64'd1, "in_ready low while buffer has space");
    end else if (!pop_same) begin
      check_value(64'(in_ready), 64'd0, "in_ready high for a full buffer");
      full_hits++;
    end else begin
      check_value(64'(in_ready), 64'd1, "in_ready low for a full buffer being read");
    end
  endtask

  task automatic check_output;
    flit_t exp_flit;
    int    v;
    v = int'(out_flit.vc);
    check_value(64'(ref_q[v].size() > 0), 64'd1, "output flit on a channel with none left");
    exp_flit = ref_q[v].pop_front();
    check_value(64'(out_flit), 64'(exp_flit), "flit differs from channel reference");
    if (fair_order) begin
      check_value(64'(out_flit.vc), 64'(out_count / 2), "fairness block out of vc order");
    end
    if (in_pkt) begin
      check_value(64'(out_flit.vc), 64'(pkt_vc), "packet interleaved with another channel");
      check_value(64'(out_flit.head), 64'd0, "new head before tail of open packet");
    end else begin
      check_value(64'(out_flit.head), 64'd1, "packet starts without a head flit");
      pkt_vc   = exp_flit.vc;
      pkt_dest = exp_flit.body.header.dest;
    end
    check_value(64'(out_dest), 64'(pkt_dest), "out_dest differs from header dest");
    in_pkt = !exp_flit.tail;
    out_count++;
  endtask

  // ########################################
  // One clock of stimulus and sampling
  // ########################################

  task automatic run_cycle;
    logic in_fire;
    logic out_fire;
    @(negedge clk);
    if (in_done) begin
      in_valid = 1'b0;
      in_done  = 1'b0;
    end
    // Next record with an idle gap now and then in the random stream
    if (!in_valid && send_idx < send_end) begin
      if (!random_gaps || (($random(seed) & 3) != 0)) begin
        in_valid = 1'b1;
        in_flit  = pat_mem[send_idx][35:0];
      end
    end
    case (ready_mode)
      READY_LOW:  out_ready = 1'b0;
      READY_HIGH: out_ready = 1'b1;
      default:    out_ready = (($random(seed) & 7) == 0);
    endcase
    // Sample well before the rising edge
    #1;
    in_fire  = in_valid && in_ready;
    out_fire = out_valid && out_ready;
    if (in_valid) begin
      check_in_ready();
    end
    if (out_fire) begin
      check_output();
      occ[out_flit.vc]--;
    end
    if (in_fire) begin
      occ[in_flit.vc]++;
      send_idx++;
      in_done = 1'b1;
    end
    last_out_fire = out_fire;
  endtask

  // ########################################
  // Test sequence
  // ########################################

  initial begin
    int waited;
    int n;
    seed          = 75;
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_flit       = '0;
    out_ready     = 1'b0;
    send_idx      = 0;
    send_end      = 0;
    ready_mode    = READY_LOW;
    random_gaps   = 1'b0;
    fair_order    = 1'b0;
    in_done       = 1'b0;
    last_out_fire = 1'b0;
    out_count     = 0;
    full_hits     = 0;
    in_pkt        = 1'b0;
    pkt_vc        = '0;
    pkt_dest      = '0;
    for (n = 0; n < VC_COUNT; n++) begin
      occ[n] = 0;
    end
    for (n = 0; n < PAT_MAX; n++) begin
      pat_mem[n] = '0;
    end
    $readmemh("flit_patterns.hex", pat_mem);
    load_references();
    check_value(64'(pat_count > FAIR_N), 64'd1, "pattern file holds too few records");

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_value(64'(out_valid), 64'd0, "out_valid high after reset");
    check_value(64'(in_ready), 64'd1, "in_ready low after reset");

    // Load vc3 down to vc0 with the output stalled
    send_end = FAIR_N;
    waited   = 0;
    while (send_idx < send_end) begin
      if (waited == WAIT_LIMIT) begin
        timeout_fail("fairness block was not accepted at the input");
      end else begin
        run_cycle();
        waited++;
      end
    end

    // Packets leave back to back from vc0 upward
    ready_mode = READY_HIGH;
    fair_order = 1'b1;
    for (n = 0; n < FAIR_N; n++) begin
      run_cycle();
      check_value(64'(last_out_fire), 64'd1, "gap while draining fairness block");
    end
    fair_order = 1'b0;

    // Random stream under random back-pressure
    ready_mode  = READY_RAND;
    random_gaps = 1'b1;
    send_end    = pat_count;
    waited      = 0;
    while (send_idx < pat_count || out_count < pat_count) begin
      if (waited == DRAIN_LIMIT) begin
        timeout_fail("random stream did not drain");
      end else begin
        run_cycle();
        waited++;
      end
    end

    // Nothing may remain once every expected flit has left
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b0;
    #1;
    check_value(64'(out_valid), 64'd0, "flit left in the DUT after the stream");
    check_value(64'(full_hits > 0), 64'd1, "no full buffer was seen at the input");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flit_patterns.hex
// Kind digit 1 then head/tail/vc digit then the 32-bit body word
// First 8 records form the fairness block
1B33030201
1700003301
1A22020202
1600002202
1911010203
1500001103
180A000204
1400000A04
// Random stream
1A45020310
1200000011
1600000012
1A46020320
1200000021
1600000022
1A47020230
1600000031
1C50000140
1951010350
1100000051
1500000052
1B60030260
1700000061
1952010270
1500000071
1861000380
1000000081
1400000082
1F62030190
1A480202A0
16000000A1
18630002B0
14000000B1
1D530101C0
1B640303D0
13000000D1
17000000D2
1E490201E0

// File: compile.f
noc_pkg.sv
flit_vc_demux.sv
vc_buffer.sv
vc_packet_arbiter.sv
noc_vc_mux_top.sv
tb_noc_vc_mux.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the NoC VC mux testbench with Verilator

set -u

# Paths in compile.f and the pattern file are relative to the project root
cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing \
    -f compile.f \
    --top-module tb_noc_vc_mux \
    -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

# Exit status of the model carries pass or fail
if ! ./obj_dir/Vtb_noc_vc_mux; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation finished"
exit 0
